// File: Bender.yml
package:
  name: csr_unit

sources:
  # packages first, then leaf modules and the top
  - csr_map_pkg.sv
  - csr_exec_pkg.sv
  - csr_alu.sv
  - csr_regfile.sv
  - trap_ctrl.sv
  - csr_unit.sv

  # testbench, top module tb_csr_unit
  - target: test
    files:
      - tb_csr_unit.sv

// File: csr_alu.sv
`timescale 1ns/1ps

module csr_alu
    import csr_exec_pkg::*;
(
    input  csr_op_e     csr_op,
    input  logic        csr_src_zero,
    input  logic [31:0] old_value,
    input  logic [31:0] operand,
    output logic [31:0] new_value,
    output logic        write_req
);

    // operand already holds rs1 or the zero-extended uimm
    always_comb begin
        new_value = old_value;
        write_req = 1'b0;
        case (csr_op)
            // plain replace, always writes
            CSRRW,
            CSRRWI: begin
                new_value = operand;
                write_req = 1'b1;
            end
            // set bits
            CSRRS,
            CSRRSI: begin
                new_value = old_value | operand;
                // x0 / zero uimm means pure read
                write_req = ~csr_src_zero;
            end
            // clear bits
            CSRRC,
            CSRRCI: begin
                new_value = old_value & ~operand;
                write_req = ~csr_src_zero;
            end
            // reserved funct3, no write
            default: begin
                new_value = old_value;
                write_req = 1'b0;
            end
        endcase
    end

endmodule

// File: csr_exec_pkg.sv
package csr_exec_pkg;

    // width of the funct3 field
    localparam int unsigned CSR_OP_W = 3;

    // csr operations, encoded as funct3
    typedef enum logic [CSR_OP_W-1:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_e;

    // synchronous exception causes, interrupt bit always clear
    typedef enum logic [31:0] {
        // standard illegal instruction
        CAUSE_ILLEGAL_INSN   = 32'd2,
        // environment call from machine mode
        CAUSE_ECALL_M        = 32'd11,
        // return-address stack mismatch, custom range 24..31
        CAUSE_STACK_MISMATCH = 32'd24
    } trap_cause_e;

    // mtval for traps without extra information
    localparam logic [31:0] TRAP_VALUE_NONE = 32'h0000_0000;

endpackage

// File: csr_map_pkg.sv
package csr_map_pkg;

    // data width of every csr
    localparam int unsigned XLEN = 32;

    // implemented machine-mode csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MCYCLE   = 12'hB00,
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

    // top two address bits both set means read-only space
    localparam logic [1:0] CSR_RO_PREFIX = 2'b11;

    // misa: mxl = 1 (32-bit), extension i
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    // mstatus field positions
    localparam int unsigned MSTATUS_MIE     = 3;
    localparam int unsigned MSTATUS_MPIE    = 7;
    localparam int unsigned MSTATUS_MPP_LSB = 11;
    // mpp hardwired to machine mode
    localparam logic [1:0]  MSTATUS_MPP_M   = 2'b11;

    // writable mie bits: msie, mtie, meie
    localparam logic [XLEN-1:0] MIE_MASK        = 32'h0000_0888;
    // mtvec bit 1 is reserved, mode stays in bit 0
    localparam logic [XLEN-1:0] MTVEC_WMASK     = 32'hFFFF_FFFD;
    localparam logic [XLEN-1:0] MTVEC_BASE_MASK = 32'hFFFF_FFFC;
    // ialign 32, low two bits of mepc always zero
    localparam logic [XLEN-1:0] MEPC_WMASK      = 32'hFFFF_FFFC;

    // single hart
    localparam logic [XLEN-1:0] HART_ID         = 32'h0000_0000;
    // reset value of every stored register
    localparam logic [XLEN-1:0] CSR_RESET_VALUE = 32'h0000_0000;

endpackage

// File: csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile
    import csr_map_pkg::*;
    import csr_exec_pkg::*;
(
    input  logic            bus,
    input  logic            rst,
    input  logic            csr_valid,
    input  logic [11:0]     csr_addr,
    // instruction write port
    input  logic            write_req,
    input  logic [XLEN-1:0] new_value,
    // trap and mret update port
    input  logic            take_trap,
    input  trap_cause_e     trap_cause,
    input  logic [XLEN-1:0] trap_value,
    input  logic [XLEN-1:0] pc,
    input  logic            do_mret,
    // outputs
    output logic [XLEN-1:0] old_value,
    output logic            illegal,
    output logic [XLEN-1:0] mtvec_base,
    output logic [XLEN-1:0] mepc_value
);

    // mstatus state, only the two enable bits are stored
    logic            status_mie;
    logic            status_mpie;
    logic [XLEN-1:0] mstatus_value;

    // plain storage
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;
    logic [XLEN-1:0] mcycle_q;

    // decode results
    logic            mapped;
    logic            read_only;
    logic            wr_en;

    // assemble mstatus from stored bits and the fixed mpp field
    always_comb begin
        mstatus_value                         = '0;
        mstatus_value[MSTATUS_MIE]            = status_mie;
        mstatus_value[MSTATUS_MPIE]           = status_mpie;
        mstatus_value[MSTATUS_MPP_LSB +: 2]   = MSTATUS_MPP_M;
    end

    // read mux, shows contents before this cycle's write
    always_comb begin
        mapped    = 1'b1;
        old_value = '0;
        case (csr_addr)
            CSR_MSTATUS:  old_value = mstatus_value;
            CSR_MISA:     old_value = MISA_VALUE;
            CSR_MIE:      old_value = mie_q;
            CSR_MTVEC:    old_value = mtvec_q;
            CSR_MSCRATCH: old_value = mscratch_q;
            CSR_MEPC:     old_value = mepc_q;
            CSR_MCAUSE:   old_value = mcause_q;
            CSR_MTVAL:    old_value = mtval_q;
            // no interrupt sources
            CSR_MIP:      old_value = '0;
            CSR_MCYCLE:   old_value = mcycle_q;
            CSR_MHARTID:  old_value = HART_ID;
            // unmapped address
            default: begin
                mapped    = 1'b0;
                old_value = '0;
            end
        endcase
    end

    // legality check
    assign read_only = (csr_addr[11:10] == CSR_RO_PREFIX);
    assign illegal   = csr_valid & (~mapped | (write_req & read_only));

    // a trap in the same cycle drops the instruction write
    assign wr_en = csr_valid & write_req & ~take_trap;

    // handler base and return address for trap control
    assign mtvec_base = mtvec_q & MTVEC_BASE_MASK;
    assign mepc_value = mepc_q;

    always_ff @(posedge bus) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_q       <= CSR_RESET_VALUE;
            mtvec_q     <= CSR_RESET_VALUE;
            mscratch_q  <= CSR_RESET_VALUE;
            mepc_q      <= CSR_RESET_VALUE;
            mcause_q    <= CSR_RESET_VALUE;
            mtval_q     <= CSR_RESET_VALUE;
            mcycle_q    <= CSR_RESET_VALUE;
        end else begin
            // free-running, a write below overrides this
            mcycle_q <= mcycle_q + 32'd1;

            // masked instruction writes
            if (wr_en) begin
                case (csr_addr)
                    CSR_MSTATUS: begin
                        status_mie  <= new_value[MSTATUS_MIE];
                        status_mpie <= new_value[MSTATUS_MPIE];
                    end
                    CSR_MIE:      mie_q      <= new_value & MIE_MASK;
                    CSR_MTVEC:    mtvec_q    <= new_value & MTVEC_WMASK;
                    CSR_MSCRATCH: mscratch_q <= new_value;
                    CSR_MEPC:     mepc_q     <= new_value & MEPC_WMASK;
                    CSR_MCAUSE:   mcause_q   <= new_value;
                    CSR_MTVAL:    mtval_q    <= new_value;
                    // counter takes the written value, no increment
                    CSR_MCYCLE:   mcycle_q   <= new_value;
                    // misa and mip writes are legal and ignored
                    default: ;
                endcase
            end

            // trap entry, overrides any mstatus field update
            if (take_trap) begin
                mepc_q      <= pc;
                mcause_q    <= trap_cause;
                mtval_q     <= trap_value;
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
            end else if (do_mret) begin
                // restore enable, mpie back to one
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
            end
        end
    end

endmodule

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_exec_pkg::*;
(
    input  logic        bus,
    input  logic        rst,
    // csr instruction
    input  logic        csr_valid,
    input  csr_op_e     csr_op,
    input  logic [11:0] csr_addr,
    input  logic [31:0] csr_operand,
    input  logic        csr_src_zero,
    // trap and return strobes
    input  logic        ecall,
    input  logic        stack_mismatch,
    input  logic [31:0] mismatch_addr,
    input  logic        mret,
    input  logic [31:0] pc,
    // results
    output logic [31:0] csr_rdata,
    output logic        csr_illegal,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    // alu <-> regfile
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        write_req;
    // regfile <-> trap control
    logic        illegal;
    logic        take_trap;
    logic        do_mret;
    trap_cause_e trap_cause;
    logic [31:0] trap_value;
    logic [31:0] mtvec_base;
    logic [31:0] mepc_value;

    // read data is the pre-write value
    assign csr_rdata   = old_value;
    assign csr_illegal = illegal;

    csr_alu u_alu (
        .csr_op       (csr_op),
        .csr_src_zero (csr_src_zero),
        .old_value    (old_value),
        .operand      (csr_operand),
        .new_value    (new_value),
        .write_req    (write_req)
    );

    csr_regfile u_regfile (
        .bus        (bus),
        .rst        (rst),
        .csr_valid  (csr_valid),
        .csr_addr   (csr_addr),
        .write_req  (write_req),
        .new_value  (new_value),
        .take_trap  (take_trap),
        .trap_cause (trap_cause),
        .trap_value (trap_value),
        .pc         (pc),
        .do_mret    (do_mret),
        .old_value  (old_value),
        .illegal    (illegal),
        .mtvec_base (mtvec_base),
        .mepc_value (mepc_value)
    );

    trap_ctrl u_trap_ctrl (
        .ecall          (ecall),
        .stack_mismatch (stack_mismatch),
        .mret           (mret),
        .illegal        (illegal),
        .mismatch_addr  (mismatch_addr),
        .csr_addr       (csr_addr),
        .mtvec_base     (mtvec_base),
        .mepc_value     (mepc_value),
        .take_trap      (take_trap),
        .do_mret        (do_mret),
        .trap_cause     (trap_cause),
        .trap_value     (trap_value),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: project.f
csr_map_pkg.sv
csr_exec_pkg.sv
csr_alu.sv
csr_regfile.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// File: tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit
    import csr_map_pkg::*;
    import csr_exec_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    // cycle budget: reset, reset values, ops, illegal, traps, mret, mcycle
    localparam int TOTAL_CYCLES = 4 + 12 + 22 + 16 + 24 + 6 + 12;
    localparam int TIMEOUT_NS = TOTAL_CYCLES * 2 * CLK_PERIOD;

    logic        bus;
    logic        rst;
    logic        csr_valid;
    csr_op_e     csr_op;
    logic [11:0] csr_addr;
    logic [31:0] csr_operand;
    logic        csr_src_zero;
    logic        ecall;
    logic        stack_mismatch;
    logic [31:0] mismatch_addr;
    logic        mret;
    logic [31:0] pc;
    logic [31:0] csr_rdata;
    logic        csr_illegal;
    logic        redirect;
    logic [31:0] redirect_pc;

    // outputs sampled at the falling edge
    logic [31:0] s_rdata;
    logic        s_illegal;
    logic        s_redirect;
    logic [31:0] s_target;

    // scoreboard model of the stored registers
    logic        m_mie;
    logic        m_mpie;
    logic [31:0] m_mie_reg;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;

    string  test_name;
    int     error_count;
    int     check_count;
    integer seed;

    csr_unit u_dut (
        .bus            (bus),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_operand    (csr_operand),
        .csr_src_zero   (csr_src_zero),
        .ecall          (ecall),
        .stack_mismatch (stack_mismatch),
        .mismatch_addr  (mismatch_addr),
        .mret           (mret),
        .pc             (pc),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc)
    );

    always #(CLK_PERIOD / 2) bus = ~bus;

    // expected contents of a csr, mcycle not modelled
    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [31:0] v;
        v = 32'h0;
        case (addr)
            CSR_MSTATUS: begin
                v[3]     = m_mie;
                v[7]     = m_mpie;
                v[12:11] = 2'b11;
            end
            CSR_MISA:     v = MISA_VALUE;
            CSR_MIE:      v = m_mie_reg;
            CSR_MTVEC:    v = m_mtvec;
            CSR_MSCRATCH: v = m_mscratch;
            CSR_MEPC:     v = m_mepc;
            CSR_MCAUSE:   v = m_mcause;
            CSR_MTVAL:    v = m_mtval;
            default:      v = 32'h0;
        endcase
        return v;
    endfunction

    // masked write into the model
    function automatic void model_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            CSR_MSTATUS: begin
                m_mie  = val[3];
                m_mpie = val[7];
            end
            CSR_MIE:      m_mie_reg  = val & MIE_MASK;
            CSR_MTVEC:    m_mtvec    = val & ~32'h2;
            CSR_MSCRATCH: m_mscratch = val;
            CSR_MEPC:     m_mepc     = val & ~32'h3;
            CSR_MCAUSE:   m_mcause   = val;
            CSR_MTVAL:    m_mtval    = val;
            default: ;
        endcase
    endfunction

    function automatic void model_trap(input trap_cause_e cause, input logic [31:0] val,
                                       input logic [31:0] epc);
        m_mepc   = epc;
        m_mcause = cause;
        m_mtval  = val;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    endfunction

    // replace, set or clear per funct3
    function automatic logic [31:0] expected_new(input csr_op_e op, input logic [31:0] old,
                                                 input logic [31:0] opnd);
        case (op)
            CSRRS, CSRRSI: return old | opnd;
            CSRRC, CSRRCI: return old & ~opnd;
            default:       return opnd;
        endcase
    endfunction

    task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_cause(input string what, input trap_cause_e exp, input trap_cause_e act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // one request per cycle, sampled half a cycle later
    task automatic drive_cycle(input logic v, input csr_op_e op, input logic [11:0] addr,
                               input logic [31:0] opnd, input logic sz, input logic ec,
                               input logic sm, input logic [31:0] ma, input logic mr,
                               input logic [31:0] p);
        @(posedge bus);
        csr_valid      <= v;
        csr_op         <= op;
        csr_addr       <= addr;
        csr_operand    <= opnd;
        csr_src_zero   <= sz;
        ecall          <= ec;
        stack_mismatch <= sm;
        mismatch_addr  <= ma;
        mret           <= mr;
        pc             <= p;
        @(negedge bus);
        s_rdata    = csr_rdata;
        s_illegal  = csr_illegal;
        s_redirect = redirect;
        s_target   = redirect_pc;
    endtask

    task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] opnd, input logic sz);
        drive_cycle(1'b1, op, addr, opnd, sz, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0000_0400);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, CSRRS, 12'h000, 32'h0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
    endtask

    // pure read: csrrs with x0
    task automatic read_expect(input logic [11:0] addr, input string what);
        csr_access(CSRRS, addr, 32'h0, 1'b1);
        check_data(what, model_read(addr), s_rdata);
    endtask

    task automatic check_trap_regs();
        read_expect(CSR_MEPC, "mepc");
        csr_access(CSRRS, CSR_MCAUSE, 32'h0, 1'b1);
        check_cause("mcause", trap_cause_e'(m_mcause), trap_cause_e'(s_rdata));
        read_expect(CSR_MTVAL, "mtval");
        read_expect(CSR_MSTATUS, "mstatus");
        check_flag("mstatus mie", m_mie, s_rdata[MSTATUS_MIE]);
        check_flag("mstatus mpie", m_mpie, s_rdata[MSTATUS_MPIE]);
    endtask

    task automatic check_handler_redirect(input string what);
        check_flag({what, " redirect"}, 1'b1, s_redirect);
        check_data({what, " target"}, m_mtvec & ~32'h3, s_target);
    endtask

    // mret from a given mstatus, enable restored and mpie set
    task automatic return_from_trap(input logic [31:0] status);
        csr_access(CSRRW, CSR_MSTATUS, status, 1'b0);
        model_write(CSR_MSTATUS, status);
        drive_cycle(1'b0, CSRRS, 12'h000, 32'h0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b1, 32'h0000_5000);
        check_flag("mret redirect", 1'b1, s_redirect);
        check_data("mret target", m_mepc, s_target);
        m_mie  = m_mpie;
        m_mpie = 1'b1;
        read_expect(CSR_MSTATUS, "mstatus");
        check_flag("mstatus mie", m_mie, s_rdata[MSTATUS_MIE]);
        check_flag("mstatus mpie", m_mpie, s_rdata[MSTATUS_MPIE]);
    endtask

    task automatic test_reset_values();
        test_name = "reset";
        read_expect(CSR_MSTATUS, "mstatus");
        read_expect(CSR_MISA, "misa");
        read_expect(CSR_MIE, "mie");
        read_expect(CSR_MTVEC, "mtvec");
        read_expect(CSR_MSCRATCH, "mscratch");
        read_expect(CSR_MEPC, "mepc");
        read_expect(CSR_MCAUSE, "mcause");
        read_expect(CSR_MTVAL, "mtval");
        read_expect(CSR_MIP, "mip");
        read_expect(CSR_MHARTID, "mhartid");
        idle_cycle();
        check_flag("idle redirect", 1'b0, s_redirect);
    endtask

    task automatic test_csr_ops();
        logic [11:0] addr;
        logic [31:0] opnd;
        csr_op_e     op;
        test_name = "csr_ops";
        for (int r = 0; r < 2; r++) begin
            addr = (r == 0) ? CSR_MSCRATCH : CSR_MIE;
            for (int i = 0; i < 6; i++) begin
                // funct3 1..3 then 5..7
                op   = csr_op_e'(3'((i < 3) ? i + 1 : i + 2));
                opnd = $random(seed);
                // immediate forms carry a zero-extended uimm
                if (op[2])
                    opnd = opnd & 32'h0000_001f;
                csr_access(op, addr, opnd, 1'b0);
                check_data("old value", model_read(addr), s_rdata);
                model_write(addr, expected_new(op, model_read(addr), opnd));
            end
            read_expect(addr, "after ops");
            // x0 source must not write
            csr_access(CSRRS, addr, 32'hffff_ffff, 1'b1);
            check_data("set x0 old", model_read(addr), s_rdata);
            csr_access(CSRRC, addr, 32'hffff_ffff, 1'b1);
            check_data("clear x0 old", model_read(addr), s_rdata);
            read_expect(addr, "after x0 ops");
        end
    endtask

    task automatic test_illegal();
        test_name = "illegal";
        csr_access(CSRRW, CSR_MTVEC, 32'h0000_1007, 1'b0);
        model_write(CSR_MTVEC, 32'h0000_1007);
        // unmapped address, even a read traps
        drive_cycle(1'b1, CSRRS, 12'h7c0, 32'h0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0000_0100);
        check_flag("unmapped illegal", 1'b1, s_illegal);
        check_handler_redirect("unmapped");
        model_trap(CAUSE_ILLEGAL_INSN, 32'h0000_07c0, 32'h0000_0100);
        check_trap_regs();
        // write into read-only space
        drive_cycle(1'b1, CSRRW, CSR_MHARTID, $random(seed), 1'b0, 1'b0, 1'b0, 32'h0, 1'b0,
                    32'h0000_0104);
        check_flag("hartid write illegal", 1'b1, s_illegal);
        check_handler_redirect("hartid write");
        model_trap(CAUSE_ILLEGAL_INSN, 32'h0000_0f14, 32'h0000_0104);
        check_trap_regs();
        read_expect(CSR_MHARTID, "mhartid unchanged");
        // read-only csr through csrrs x0 stays legal
        csr_access(CSRRS, CSR_MHARTID, 32'h0, 1'b1);
        check_flag("hartid read illegal", 1'b0, s_illegal);
        check_flag("hartid read redirect", 1'b0, s_redirect);
    endtask

    task automatic test_traps();
        logic [31:0] ma;
        logic [31:0] wval;
        test_name = "traps";
        csr_access(CSRRSI, CSR_MSTATUS, 32'h8, 1'b0);
        model_write(CSR_MSTATUS, expected_new(CSRRSI, model_read(CSR_MSTATUS), 32'h8));
        drive_cycle(1'b0, CSRRS, 12'h000, 32'h0, 1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0000_2468);
        check_handler_redirect("ecall");
        model_trap(CAUSE_ECALL_M, 32'h0, 32'h0000_2468);
        check_trap_regs();
        // stack mismatch with mie set again
        csr_access(CSRRSI, CSR_MSTATUS, 32'h8, 1'b0);
        model_write(CSR_MSTATUS, expected_new(CSRRSI, model_read(CSR_MSTATUS), 32'h8));
        ma = $random(seed);
        drive_cycle(1'b0, CSRRS, 12'h000, 32'h0, 1'b1, 1'b0, 1'b1, ma, 1'b0, 32'h0000_3000);
        check_handler_redirect("mismatch");
        model_trap(CAUSE_STACK_MISMATCH, ma, 32'h0000_3000);
        check_trap_regs();
        // both at once plus a csr write, mismatch wins and the write drops
        ma   = $random(seed);
        wval = $random(seed);
        drive_cycle(1'b1, CSRRW, CSR_MSCRATCH, wval, 1'b0, 1'b1, 1'b1, ma, 1'b0, 32'h0000_3100);
        check_flag("both illegal", 1'b0, s_illegal);
        check_handler_redirect("both");
        model_trap(CAUSE_STACK_MISMATCH, ma, 32'h0000_3100);
        check_trap_regs();
        read_expect(CSR_MSCRATCH, "mscratch kept");
    endtask

    task automatic test_mret();
        test_name = "mret";
        // mpie set, mie clear
        return_from_trap(32'h0000_0080);
        // mie set, mpie clear
        return_from_trap(32'h0000_0008);
    endtask

    task automatic test_mcycle();
        logic [31:0] first;
        test_name = "mcycle";
        csr_access(CSRRS, CSR_MCYCLE, 32'h0, 1'b1);
        first = s_rdata;
        repeat (4) idle_cycle();
        // second read five edges later
        csr_access(CSRRS, CSR_MCYCLE, 32'h0, 1'b1);
        check_data("delta", first + 32'd5, s_rdata);
        csr_access(CSRRW, CSR_MCYCLE, 32'h1000_0000, 1'b0);
        csr_access(CSRRS, CSR_MCYCLE, 32'h0, 1'b1);
        check_data("written", 32'h1000_0000, s_rdata);
        repeat (2) idle_cycle();
        csr_access(CSRRS, CSR_MCYCLE, 32'h0, 1'b1);
        check_data("after write", 32'h1000_0003, s_rdata);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        bus            = 1'b0;
        rst            = 1'b1;
        csr_valid      = 1'b0;
        csr_op         = CSRRS;
        csr_addr       = 12'h000;
        csr_operand    = 32'h0;
        csr_src_zero   = 1'b1;
        ecall          = 1'b0;
        stack_mismatch = 1'b0;
        mismatch_addr  = 32'h0;
        mret           = 1'b0;
        pc             = 32'h0;
        seed           = 32'hc5633826;
        error_count    = 0;
        check_count    = 0;
        // model reset state
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mie_reg  = 32'h0;
        m_mtvec    = 32'h0;
        m_mscratch = 32'h0;
        m_mepc     = 32'h0;
        m_mcause   = 32'h0;
        m_mtval    = 32'h0;
        repeat (3) @(posedge bus);
        rst <= 1'b0;
        test_reset_values();
        test_csr_ops();
        test_illegal();
        test_traps();
        test_mret();
        test_mcycle();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl
    import csr_exec_pkg::*;
(
    input  logic        ecall,
    input  logic        stack_mismatch,
    input  logic        mret,
    input  logic        illegal,
    input  logic [31:0] mismatch_addr,
    input  logic [11:0] csr_addr,
    input  logic [31:0] mtvec_base,
    input  logic [31:0] mepc_value,
    output logic        take_trap,
    output logic        do_mret,
    output trap_cause_e trap_cause,
    output logic [31:0] trap_value,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    // fixed priority: stack mismatch, illegal csr, ecall
    always_comb begin
        take_trap  = 1'b1;
        trap_cause = CAUSE_ECALL_M;
        trap_value = TRAP_VALUE_NONE;
        if (stack_mismatch) begin
            // offending return address goes to mtval
            trap_cause = CAUSE_STACK_MISMATCH;
            trap_value = mismatch_addr;
        end else if (illegal) begin
            // faulting csr number, zero-extended
            trap_cause = CAUSE_ILLEGAL_INSN;
            trap_value = {20'h0_0000, csr_addr};
        end else if (ecall) begin
            trap_cause = CAUSE_ECALL_M;
            trap_value = TRAP_VALUE_NONE;
        end else begin
            take_trap  = 1'b0;
        end
    end

    // mret loses to any trap in the same cycle
    assign do_mret = mret & ~take_trap;

    // fetch redirect, same cycle as the request
    assign redirect = take_trap | do_mret;

    // handler base on a trap, return address on mret
    always_comb begin
        if (take_trap) begin
            redirect_pc = mtvec_base;
        end else if (do_mret) begin
            redirect_pc = mepc_value;
        end else begin
            // idle
            redirect_pc = '0;
        end
    end

endmodule
